// ==== source/rx_stream_pkg.sv ====
//**********************************************************************
// Shared widths, types and statistics layout of the receive capture path.
// Imported by every module of the receive capture design.
//**********************************************************************
package rx_stream_pkg;

	localparam int DATA_WIDTH = 64;		// beat width in bits.
	localparam int STRB_WIDTH = 8;		// one strobe bit per byte.

	typedef logic [DATA_WIDTH-1:0]	data_t;		// one quadword of frame data.
	typedef logic [STRB_WIDTH-1:0]	strb_t;		// byte strobe of a beat.
	typedef logic [15:0]			bcnt_t;		// frame byte count, saturating.
	typedef logic [7:0]				qwd_cnt_t;	// beat count and buffer pointer.
	typedef logic [25:0]			rx_stat_t;	// end of frame statistics.

	localparam int STAT_BCNT_LSB = 0;	// byte count, bits 15..0.
	localparam int STAT_QWD_LSB  = 16;	// beat count, bits 23..16.
	localparam int STAT_BAD_BIT  = 24;	// tuser seen on the last beat.
	localparam int STAT_OVF_BIT  = 25;	// frame did not fit its buffer.

	typedef enum logic [1:0]
	{
		DRAIN_IDLE,						// waiting on a ready buffer.
		DRAIN_REQ,						// rd_req up, waiting on rd_ack.
		DRAIN_RELEASE					// rd_req down, waiting on rd_ack low.
	} drain_state_t;

	// only low aligned contiguous strobes carry bytes.
	function automatic bcnt_t strb_bytes(input strb_t strb);
		case (strb)
			8'h01	: return bcnt_t'(1);
			8'h03	: return bcnt_t'(2);
			8'h07	: return bcnt_t'(3);
			8'h0f	: return bcnt_t'(4);
			8'h1f	: return bcnt_t'(5);
			8'h3f	: return bcnt_t'(6);
			8'h7f	: return bcnt_t'(7);
			8'hff	: return bcnt_t'(8);
			default	: return bcnt_t'(0);	// gaps or high aligned strobes.
		endcase
	endfunction

endpackage

// ==== source/rx_frame_buffer.sv ====
//**********************************************************************
// One frame buffer. Written beat by beat from the dispatch, read beat by
// beat by the drain. Holds at most one frame at a time.
//**********************************************************************
module rx_frame_buffer #(
	parameter int MAX_BEATS = 16
) (
	input  logic					rx_mac_aclk,
	input  logic					reset_,
	input  logic					wr_en,
	input  rx_stream_pkg::data_t	wr_data,
	input  rx_stream_pkg::strb_t	wr_strb,
	input  logic					wr_last,
	input  logic					rd_en,
	output logic					frame_ready,
	output rx_stream_pkg::data_t	rd_data,
	output rx_stream_pkg::strb_t	rd_strb,
	output logic					rd_last
);
	import rx_stream_pkg::*;

	localparam int AW = (MAX_BEATS > 1) ? $clog2(MAX_BEATS) : 1;

	data_t		data_mem [MAX_BEATS];	// beat payload.
	strb_t		strb_mem [MAX_BEATS];	// beat strobes.
	logic		last_mem [MAX_BEATS];	// marks the final stored beat.
	qwd_cnt_t	wr_ptr;					// next entry to write.
	qwd_cnt_t	rd_ptr;					// entry shown on the read side.
	logic [AW-1:0]	wr_idx;
	logic [AW-1:0]	rd_idx;

	assign wr_idx = wr_ptr[AW-1:0];
	assign rd_idx = rd_ptr[AW-1:0];

	always_ff @(posedge rx_mac_aclk)
	begin
		if (wr_en)
		begin
			data_mem[wr_idx] <= wr_data;
			strb_mem[wr_idx] <= wr_strb;
			last_mem[wr_idx] <= wr_last;
		end
	end

	always_ff @(posedge rx_mac_aclk)
	begin
		if (!reset_)
		begin
			wr_ptr      <= '0;
			rd_ptr      <= '0;
			frame_ready <= 1'b0;
		end
		else if (rd_en && rd_last)
		begin
			wr_ptr      <= '0;				// frame gone, buffer free again.
			rd_ptr      <= '0;
			frame_ready <= 1'b0;
		end
		else
		begin
			if (wr_en)
			begin
				wr_ptr <= wr_ptr + 1'b1;
				if (wr_last)
					frame_ready <= 1'b1;		// complete frame held.
			end
			if (rd_en)
				rd_ptr <= rd_ptr + 1'b1;
		end
	end

	// read side is combinational at the read pointer.
	assign rd_data = data_mem[rd_idx];
	assign rd_strb = strb_mem[rd_idx];
	assign rd_last = last_mem[rd_idx];

	a_no_wr_full: assert property (@(posedge rx_mac_aclk) disable iff (!reset_)
		wr_en |-> !frame_ready);
	a_no_rd_empty: assert property (@(posedge rx_mac_aclk) disable iff (!reset_)
		rd_en |-> frame_ready);

endmodule

// ==== source/rx_frame_dispatch.sv ====
//**********************************************************************
// Receive side of the MAC stream. Accepts beats, counts bytes and beats,
// writes each frame into the next free buffer in turn and publishes a
// statistics vector at the end of every frame.
//**********************************************************************
module rx_frame_dispatch #(
	parameter int NUM_BUFS  = 4,
	parameter int MAX_BEATS = 16
) (
	input  logic					rx_mac_aclk,
	input  logic					reset_,
	input  rx_stream_pkg::data_t	rx_axis_mac_tdata,
	input  logic					rx_axis_mac_tvalid,
	input  logic					rx_axis_mac_tlast,
	input  logic					rx_axis_mac_tuser,
	input  rx_stream_pkg::strb_t	rx_axis_mac_tstrb,
	input  logic [NUM_BUFS-1:0]		buf_frame_ready,
	output logic					rx_axis_mac_tready,
	output logic [NUM_BUFS-1:0]		buf_wr_en,
	output rx_stream_pkg::data_t	buf_wr_data,
	output rx_stream_pkg::strb_t	buf_wr_strb,
	output logic					buf_wr_last,
	output rx_stream_pkg::rx_stat_t	rx_statistics_vector,
	output logic					rx_statistics_valid
);
	import rx_stream_pkg::*;

	localparam int SEL_W = (NUM_BUFS > 1) ? $clog2(NUM_BUFS) : 1;
	localparam int BW = $bits(bcnt_t);
	localparam logic [NUM_BUFS-1:0] SEL_ONE = 1;
	localparam qwd_cnt_t QWD_MAX = qwd_cnt_t'(MAX_BEATS);

	logic [SEL_W-1:0]	wr_sel;			// buffer that takes the current frame.
	logic [SEL_W-1:0]	wr_sel_nx;
	bcnt_t				bcnt;			// bytes so far in this frame.
	bcnt_t				bcnt_nx;
	logic [BW:0]		bcnt_sum;		// one extra bit to catch the wrap.
	qwd_cnt_t			qwd_cnt;		// beats so far in this frame.
	qwd_cnt_t			qwd_cnt_inc;
	qwd_cnt_t			qwd_cnt_nx;
	logic				ovf;			// a beat was dropped in this frame.
	logic				ovf_nx;
	logic				accept;
	logic				dropping;		// buffer full, beats only counted.

	assign accept      = rx_axis_mac_tvalid && rx_axis_mac_tready;
	assign dropping    = (qwd_cnt >= QWD_MAX);
	assign bcnt_sum    = {1'b0, bcnt} + {1'b0, strb_bytes(rx_axis_mac_tstrb)};
	assign bcnt_nx     = bcnt_sum[BW] ? '1 : bcnt_sum[BW-1:0];	// hold at max.
	assign qwd_cnt_inc = (qwd_cnt == '1) ? qwd_cnt : qwd_cnt + 1'b1;
	assign ovf_nx      = ovf || dropping;

	assign buf_wr_en   = (accept && !dropping) ? (SEL_ONE << wr_sel) : '0;
	assign buf_wr_data = rx_axis_mac_tdata;
	assign buf_wr_strb = rx_axis_mac_tstrb;
	assign buf_wr_last = rx_axis_mac_tlast || (qwd_cnt_inc == QWD_MAX);	// tlast or full.

	always_comb
	begin
		wr_sel_nx  = wr_sel;
		qwd_cnt_nx = qwd_cnt;
		if (accept && rx_axis_mac_tlast)
		begin
			wr_sel_nx  = (wr_sel == SEL_W'(NUM_BUFS - 1)) ? '0 : wr_sel + 1'b1;
			qwd_cnt_nx = '0;						// next frame starts empty.
		end
		else if (accept)
			qwd_cnt_nx = qwd_cnt_inc;
	end

	always_ff @(posedge rx_mac_aclk)
	begin
		if (!reset_)
		begin
			wr_sel              <= '0;
			qwd_cnt             <= '0;
			bcnt                <= '0;
			ovf                 <= 1'b0;
			rx_axis_mac_tready  <= 1'b0;
			rx_statistics_valid <= 1'b0;
		end
		else
		begin
			wr_sel  <= wr_sel_nx;
			qwd_cnt <= qwd_cnt_nx;
			// ready once the target is empty and not just filled, or while the tail is thrown away.
			rx_axis_mac_tready  <= !(buf_frame_ready[wr_sel_nx] ||
				(buf_wr_en[wr_sel_nx] && buf_wr_last)) || (qwd_cnt_nx >= QWD_MAX);
			rx_statistics_valid <= accept && rx_axis_mac_tlast;	// one cycle pulse.
			if (accept && rx_axis_mac_tlast)
			begin
				bcnt <= '0;
				ovf  <= 1'b0;
			end
			else if (accept)
			begin
				bcnt <= bcnt_nx;
				ovf  <= ovf_nx;
			end
		end
	end

	always_ff @(posedge rx_mac_aclk)
	begin
		if (accept && rx_axis_mac_tlast)
		begin
			rx_statistics_vector[STAT_BCNT_LSB +: BW]              <= bcnt_nx;
			rx_statistics_vector[STAT_QWD_LSB +: $bits(qwd_cnt_t)] <= qwd_cnt_inc;
			rx_statistics_vector[STAT_BAD_BIT]                     <= rx_axis_mac_tuser;
			rx_statistics_vector[STAT_OVF_BIT]                     <= ovf_nx;
		end
	end

	// a buffer that still holds a frame must never see a new one start.
	a_tready_free: assert property (@(posedge rx_mac_aclk) disable iff (!reset_)
		rx_axis_mac_tready |-> (!buf_frame_ready[wr_sel] || dropping));

endmodule

// ==== source/rx_frame_drain.sv ====
//**********************************************************************
// Readout of stored frames. Visits the buffers in dispatch order and
// hands each beat to the host with a four-phase req/ack handshake.
//**********************************************************************
module rx_frame_drain #(
	parameter int NUM_BUFS = 4
) (
	input  logic					rx_mac_aclk,
	input  logic					reset_,
	input  logic [NUM_BUFS-1:0]		buf_frame_ready,
	input  rx_stream_pkg::data_t	buf_rd_data [NUM_BUFS],
	input  rx_stream_pkg::strb_t	buf_rd_strb [NUM_BUFS],
	input  logic [NUM_BUFS-1:0]		buf_rd_last,
	input  logic					rd_ack,
	output logic [NUM_BUFS-1:0]		buf_rd_en,
	output logic					rd_req,
	output rx_stream_pkg::data_t	rd_data,
	output rx_stream_pkg::strb_t	rd_strb,
	output logic					rd_last
);
	import rx_stream_pkg::*;

	localparam int SEL_W = (NUM_BUFS > 1) ? $clog2(NUM_BUFS) : 1;
	localparam logic [NUM_BUFS-1:0] SEL_ONE = 1;

	drain_state_t		state;
	logic [SEL_W-1:0]	rd_sel;			// buffer being read, same order as dispatch.
	logic				load;			// take the next beat this cycle.

	// next beat comes from idle on a ready buffer, or straight after release.
	assign load = buf_frame_ready[rd_sel] &&
		((state == DRAIN_IDLE) || ((state == DRAIN_RELEASE) && !rd_ack && !rd_last));
	assign buf_rd_en = load ? (SEL_ONE << rd_sel) : '0;

	always_ff @(posedge rx_mac_aclk)
	begin
		if (!reset_)
		begin
			state  <= DRAIN_IDLE;
			rd_sel <= '0;
			rd_req <= 1'b0;
		end
		else
		begin
			case (state)
				DRAIN_IDLE:
				begin
					if (load)
					begin
						rd_req <= 1'b1;				// data latched in the same edge.
						state  <= DRAIN_REQ;
					end
				end
				DRAIN_REQ:
				begin
					if (rd_ack)
					begin
						rd_req <= 1'b0;
						state  <= DRAIN_RELEASE;
					end
				end
				DRAIN_RELEASE:
				begin
					if (!rd_ack && rd_last)
					begin
						rd_sel <= (rd_sel == SEL_W'(NUM_BUFS - 1)) ? '0 : rd_sel + 1'b1;
						state  <= DRAIN_IDLE;		// frame done, move to next buffer.
					end
					else if (load)
					begin
						rd_req <= 1'b1;				// next beat of the same frame.
						state  <= DRAIN_REQ;
					end
				end
				default: state <= DRAIN_IDLE;
			endcase
		end
	end

	// output registers only change while rd_req is low.
	always_ff @(posedge rx_mac_aclk)
	begin
		if (load)
		begin
			rd_data <= buf_rd_data[rd_sel];
			rd_strb <= buf_rd_strb[rd_sel];
			rd_last <= buf_rd_last[rd_sel];
		end
	end

	a_req_after_ack_low: assert property (@(posedge rx_mac_aclk) disable iff (!reset_)
		$rose(rd_req) |-> !rd_ack);

endmodule

// ==== source/rx_stream_capture.sv ====
//**********************************************************************
// Top level of the receive capture path. MAC stream in, statistics out,
// stored frames read by the host over a req/ack handshake.
//**********************************************************************
module rx_stream_capture #(
	parameter int NUM_BUFS  = 4,
	parameter int MAX_BEATS = 16			// at most 255, pointers are 8 bits.
) (
	input  logic					rx_mac_aclk,
	input  logic					reset_,
	input  rx_stream_pkg::data_t	rx_axis_mac_tdata,
	input  logic					rx_axis_mac_tvalid,
	input  logic					rx_axis_mac_tlast,
	input  logic					rx_axis_mac_tuser,
	input  rx_stream_pkg::strb_t	rx_axis_mac_tstrb,
	input  logic					rd_ack,
	output logic					rx_axis_mac_tready,
	output rx_stream_pkg::rx_stat_t	rx_statistics_vector,
	output logic					rx_statistics_valid,
	output logic					rd_req,
	output rx_stream_pkg::data_t	rd_data,
	output rx_stream_pkg::strb_t	rd_strb,
	output logic					rd_last
);
	import rx_stream_pkg::*;

	logic [NUM_BUFS-1:0]	buf_wr_en;			// one hot write select.
	data_t					buf_wr_data;
	strb_t					buf_wr_strb;
	logic					buf_wr_last;
	logic [NUM_BUFS-1:0]	buf_frame_ready;	// buffer holds a whole frame.
	logic [NUM_BUFS-1:0]	buf_rd_en;			// one hot read advance.
	data_t					buf_rd_data [NUM_BUFS];
	strb_t					buf_rd_strb [NUM_BUFS];
	logic [NUM_BUFS-1:0]	buf_rd_last;

	rx_frame_dispatch #(
		.NUM_BUFS				(NUM_BUFS),
		.MAX_BEATS				(MAX_BEATS)
	) u_dispatch (
		.rx_mac_aclk			(rx_mac_aclk),
		.reset_					(reset_),
		.rx_axis_mac_tdata		(rx_axis_mac_tdata),
		.rx_axis_mac_tvalid		(rx_axis_mac_tvalid),
		.rx_axis_mac_tlast		(rx_axis_mac_tlast),
		.rx_axis_mac_tuser		(rx_axis_mac_tuser),
		.rx_axis_mac_tstrb		(rx_axis_mac_tstrb),
		.buf_frame_ready		(buf_frame_ready),
		.rx_axis_mac_tready		(rx_axis_mac_tready),
		.buf_wr_en				(buf_wr_en),
		.buf_wr_data			(buf_wr_data),
		.buf_wr_strb			(buf_wr_strb),
		.buf_wr_last			(buf_wr_last),
		.rx_statistics_vector	(rx_statistics_vector),
		.rx_statistics_valid	(rx_statistics_valid)
	);

	for (genvar i = 0; i < NUM_BUFS; i++)
	begin : g_buf
		rx_frame_buffer #(
			.MAX_BEATS		(MAX_BEATS)
		) u_buf (
			.rx_mac_aclk	(rx_mac_aclk),
			.reset_			(reset_),
			.wr_en			(buf_wr_en[i]),
			.wr_data		(buf_wr_data),		// shared, only one buffer enabled.
			.wr_strb		(buf_wr_strb),
			.wr_last		(buf_wr_last),
			.rd_en			(buf_rd_en[i]),
			.frame_ready	(buf_frame_ready[i]),
			.rd_data		(buf_rd_data[i]),
			.rd_strb		(buf_rd_strb[i]),
			.rd_last		(buf_rd_last[i])
		);
	end

	rx_frame_drain #(
		.NUM_BUFS			(NUM_BUFS)
	) u_drain (
		.rx_mac_aclk		(rx_mac_aclk),
		.reset_				(reset_),
		.buf_frame_ready	(buf_frame_ready),
		.buf_rd_data		(buf_rd_data),
		.buf_rd_strb		(buf_rd_strb),
		.buf_rd_last		(buf_rd_last),
		.rd_ack				(rd_ack),
		.buf_rd_en			(buf_rd_en),
		.rd_req				(rd_req),
		.rd_data			(rd_data),
		.rd_strb			(rd_strb),
		.rd_last			(rd_last)
	);

endmodule

// ==== dv/rx_stream_capture_tb.sv ====
//**********************************************************************
// Directed testbench of the receive capture path. A MAC model sends
// frames, a host model reads them back over req/ack, and each result is
// compared with the value that the frame and statistics rules give.
//**********************************************************************
module rx_stream_capture_tb;
	import rx_stream_pkg::*;

	localparam int NUM_BUFS     = 4;
	localparam int MAX_BEATS    = 16;
	localparam int RESET_CYCLES = 10;
	localparam int FRAME_CYCLES = 400;			// watchdog budget per frame.
	localparam int TEST_FRAMES  = 17;			// 1 + 9 + 1 + 1 + 5 frames.
	localparam int unsigned SEED = 32'hd4b6377b;

	logic		rx_mac_aclk;
	logic		reset_;
	data_t		rx_axis_mac_tdata;
	logic		rx_axis_mac_tvalid;
	logic		rx_axis_mac_tlast;
	logic		rx_axis_mac_tuser;
	strb_t		rx_axis_mac_tstrb;
	logic		rx_axis_mac_tready;
	rx_stat_t	rx_statistics_vector;
	logic		rx_statistics_valid;
	logic		rd_req;
	logic		rd_ack;
	data_t		rd_data;
	strb_t		rd_strb;
	logic		rd_last;

	rx_stat_t	stat_q [$];						// statistics seen on the valid pulse.
	data_t		exp_data [$];					// beats the host should read, in order.
	strb_t		exp_strb [$];
	logic		exp_last [$];

	rx_stream_capture #(
		.NUM_BUFS				(NUM_BUFS),
		.MAX_BEATS				(MAX_BEATS)
	) u_rx_stream_capture (
		.rx_mac_aclk			(rx_mac_aclk),
		.reset_					(reset_),
		.rx_axis_mac_tdata		(rx_axis_mac_tdata),
		.rx_axis_mac_tvalid		(rx_axis_mac_tvalid),
		.rx_axis_mac_tlast		(rx_axis_mac_tlast),
		.rx_axis_mac_tuser		(rx_axis_mac_tuser),
		.rx_axis_mac_tstrb		(rx_axis_mac_tstrb),
		.rd_ack					(rd_ack),
		.rx_axis_mac_tready		(rx_axis_mac_tready),
		.rx_statistics_vector	(rx_statistics_vector),
		.rx_statistics_valid	(rx_statistics_valid),
		.rd_req					(rd_req),
		.rd_data				(rd_data),
		.rd_strb				(rd_strb),
		.rd_last				(rd_last)
	);

	initial
	begin
		rx_mac_aclk = 1'b0;
		forever #10 rx_mac_aclk = ~rx_mac_aclk;	// 20 unit period.
	end

	task automatic abort_run(input string msg);
		$display("%s", msg);
		$display("CHECKS FAILED");
		$fatal(1, "run stopped at time %0t", $time);
	endtask

	task automatic check_data(input string name, input data_t exp, input data_t act);
		if (act !== exp)
			abort_run($sformatf("FAIL time=%0t %s expected=%h actual=%h", $time, name, exp, act));
	endtask

	task automatic check_strb(input string name, input strb_t exp, input strb_t act);
		if (act !== exp)
			abort_run($sformatf("FAIL time=%0t %s expected=%h actual=%h", $time, name, exp, act));
	endtask

	task automatic check_stat(input string name, input rx_stat_t exp, input rx_stat_t act);
		if (act !== exp)
			abort_run($sformatf("FAIL time=%0t %s expected=%h actual=%h", $time, name, exp, act));
	endtask

	task automatic check_bit(input string name, input logic exp, input logic act);
		if (act !== exp)
			abort_run($sformatf("FAIL time=%0t %s expected=%b actual=%b", $time, name, exp, act));
	endtask

	// statistics layout: bytes 15..0, beats 23..16, bad 24, overflow 25.
	function automatic rx_stat_t make_stat(input int bytes, input int beats, input logic bad,
		input logic ovf);
		rx_stat_t s;
		s = '0;
		s[STAT_BCNT_LSB +: 16] = bytes[15:0];
		s[STAT_QWD_LSB +: 8]   = beats[7:0];
		s[STAT_BAD_BIT]        = bad;
		s[STAT_OVF_BIT]        = ovf;
		return s;
	endfunction

	// mac model, full strobes except the last beat, tuser only on tlast.
	task automatic send_frame(input int beats, input strb_t last_strb, input logic bad);
		data_t	beat_data [$];
		strb_t	beat_strb [$];
		int		kept;
		kept = (beats < MAX_BEATS) ? beats : MAX_BEATS;	// tail beyond depth is dropped.
		for (int i = 0; i < beats; i++)
		begin
			beat_data.push_back({$urandom, $urandom});
			beat_strb.push_back((i == beats - 1) ? last_strb : 8'hff);
		end
		for (int i = 0; i < kept; i++)
		begin
			exp_data.push_back(beat_data[i]);
			exp_strb.push_back(beat_strb[i]);
			exp_last.push_back(i == kept - 1);		// last stored beat carries rd_last.
		end
		for (int i = 0; i < beats; i++)
		begin
			rx_axis_mac_tdata  <= beat_data[i];
			rx_axis_mac_tstrb  <= beat_strb[i];
			rx_axis_mac_tlast  <= (i == beats - 1);
			rx_axis_mac_tuser  <= bad && (i == beats - 1);
			rx_axis_mac_tvalid <= 1'b1;
			@(posedge rx_mac_aclk);
			while (!rx_axis_mac_tready)
				@(posedge rx_mac_aclk);			// beat held until accepted.
		end
		rx_axis_mac_tvalid <= 1'b0;
		rx_axis_mac_tlast  <= 1'b0;
		rx_axis_mac_tuser  <= 1'b0;
		@(posedge rx_mac_aclk);
		check_bit("rx_statistics_valid", 1'b1, rx_statistics_valid);	// pulse after tlast.
	endtask

	// host model, one four-phase transfer.
	task automatic read_beat(output data_t d, output strb_t s, output logic l);
		@(posedge rx_mac_aclk);
		while (!rd_req)
			@(posedge rx_mac_aclk);
		d = rd_data;							// stable while rd_req is high.
		s = rd_strb;
		l = rd_last;
		rd_ack <= 1'b1;
		@(posedge rx_mac_aclk);
		while (rd_req)
			@(posedge rx_mac_aclk);
		rd_ack <= 1'b0;
	endtask

	task automatic read_frame();
		data_t	d;
		strb_t	s;
		logic	l;
		do
		begin
			read_beat(d, s, l);
			if (exp_data.size() == 0)
				abort_run("host read a beat that no frame should have left in the buffers");
			check_data("rd_data", exp_data.pop_front(), d);
			check_strb("rd_strb", exp_strb.pop_front(), s);
			check_bit("rd_last", exp_last.pop_front(), l);
		end
		while (!l);
	endtask

	task automatic expect_stat(input rx_stat_t exp);
		while (stat_q.size() == 0)
			@(posedge rx_mac_aclk);
		check_stat("rx_statistics_vector", exp, stat_q.pop_front());
	endtask

	task automatic test_single_frame();
		send_frame(5, 8'h07, 1'b0);
		expect_stat(make_stat(35, 5, 1'b0, 1'b0));
		read_frame();
	endtask

	task automatic test_byte_count();
		for (int n = 1; n <= 8; n++)
		begin
			send_frame(2, strb_t'(8'hff >> (8 - n)), 1'b0);	// n low bytes.
			expect_stat(make_stat(8 + n, 2, 1'b0, 1'b0));
			read_frame();
		end
		send_frame(2, 8'h05, 1'b0);				// gap in the strobe, no bytes.
		expect_stat(make_stat(8, 2, 1'b0, 1'b0));
		read_frame();
	endtask

	task automatic test_bad_frame();
		send_frame(4, 8'hff, 1'b1);
		expect_stat(make_stat(32, 4, 1'b1, 1'b0));
		read_frame();
	endtask

	task automatic test_overflow();
		send_frame(MAX_BEATS + 3, 8'hff, 1'b0);
		expect_stat(make_stat(8 * (MAX_BEATS + 3), MAX_BEATS + 3, 1'b0, 1'b1));
		read_frame();							// only the first MAX_BEATS come back.
	endtask

	task automatic test_backpressure();
		for (int f = 0; f < NUM_BUFS; f++)
		begin
			send_frame(3, 8'hff, 1'b0);			// host idle, buffers fill up.
			expect_stat(make_stat(24, 3, 1'b0, 1'b0));
		end
		fork
			send_frame(3, 8'hff, 1'b0);
			begin
				repeat (50)
				begin
					@(posedge rx_mac_aclk);
					check_bit("rx_axis_mac_tready", 1'b0, rx_axis_mac_tready);
				end
				for (int f = 0; f <= NUM_BUFS; f++)
					read_frame();				// host resumes, send order expected.
			end
		join
		expect_stat(make_stat(24, 3, 1'b0, 1'b0));
	endtask

	initial
	begin
		fork
			forever
			begin
				@(posedge rx_mac_aclk);
				if (rx_statistics_valid)
					stat_q.push_back(rx_statistics_vector);
			end
		join_none
	end

	initial
	begin
		repeat (RESET_CYCLES + FRAME_CYCLES * TEST_FRAMES)
			@(posedge rx_mac_aclk);
		abort_run("timeout: the tests did not finish within the watchdog limit");
	end

	initial
	begin
		void'($urandom(SEED));
		reset_             <= 1'b0;
		rx_axis_mac_tdata  <= '0;
		rx_axis_mac_tvalid <= 1'b0;
		rx_axis_mac_tlast  <= 1'b0;
		rx_axis_mac_tuser  <= 1'b0;
		rx_axis_mac_tstrb  <= '0;
		rd_ack             <= 1'b0;
		repeat (RESET_CYCLES)
			@(posedge rx_mac_aclk);
		reset_ <= 1'b1;
		@(posedge rx_mac_aclk);
		test_single_frame();
		test_byte_count();
		test_bad_frame();
		test_overflow();
		test_backpressure();
		repeat (5)
			@(posedge rx_mac_aclk);				// let a stray statistics pulse land.
		if ((stat_q.size() != 0) || (exp_data.size() != 0))
			abort_run("statistics or stored beats left over after the last test");
		else
		begin
			$display("ALL CHECKS PASSED");
			$finish;
		end
	end

endmodule

// ==== vlog.f ====
source/rx_stream_pkg.sv
source/rx_frame_buffer.sv
source/rx_frame_dispatch.sv
source/rx_frame_drain.sv
source/rx_stream_capture.sv
dv/rx_stream_capture_tb.sv

// ==== Makefile ====
# Verilator build and run for the receive capture testbench.
SIM       = verilator
TOP       = rx_stream_capture_tb
FILELIST  = vlog.f
FLAGS     = --binary --timing --assert -Wno-fatal
BUILD_DIR = obj_dir
LOG       = sim.log
PASS_MSG  = ALL CHECKS PASSED

.PHONY: all compile run clean

all: run

compile:
	$(SIM) $(FLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)

run: compile
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	@grep -q "$(PASS_MSG)" $(LOG) && echo "run passed" || \
		(echo "run failed, see $(LOG)"; exit 1)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
